// File: sim.f
rtl/lsu_core_pkg.sv
rtl/ldq_pkg.sv
rtl/ldq_alloc_if.sv
rtl/ldq_entry_if.sv
rtl/ldq_disp_pickup.sv
rtl/ldq_entry.sv
rtl/ldq_replay_arb.sv
rtl/ldq_order_ctrl.sv
rtl/ldq_top.sv
verification/ldq_checker.sv
verification/ldq_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ldq_tb -f sim.f -o ldq_sim

output=$(./obj_dir/ldq_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1

// File: verification/ldq_tb.sv
`timescale 1ns/1ps

module ldq_tb;
  import lsu_core_pkg::*;
  import ldq_pkg::*;

  localparam int RAND_LOADS     = 60;
  localparam int DIRECTED_LOADS = 8;
  localparam int TIMEOUT_CYCLES = 40 * (RAND_LOADS + DIRECTED_LOADS) + 100;
  localparam logic [15:0] LFSR_SEED = 16'd74;

  logic                     i_clk;
  logic                     i_reset_n;
  logic [DISP_SIZE-1:0]     i_disp_valid;
  disp_t                    i_disp [DISP_SIZE];
  logic [CMT_ID_W-1:0]      i_disp_cmt_id;
  ex1_update_t              i_ex1_update [LSU_INST_NUM];
  ex2_update_t              i_ex2_update [LSU_INST_NUM];
  logic [LSU_INST_NUM-1:0]  i_tlb_resolve;
  lrq_resolve_t             i_lrq_resolve;
  logic [LSU_INST_NUM-1:0]  o_replay_valid;
  issue_t                   o_replay_issue    [LSU_INST_NUM];
  logic [LDQ_SIZE-1:0]      o_replay_index_oh [LSU_INST_NUM];
  done_rpt_t                o_done_report;

  // Reference model of the queue
  ldq_state_t           m_state [LDQ_SIZE];
  logic                 m_valid [LDQ_SIZE];
  logic [CMT_ID_W-1:0]  m_cmt   [LDQ_SIZE];
  logic [DISP_SIZE-1:0] m_grp   [LDQ_SIZE];
  logic [INST_W-1:0]    m_inst  [LDQ_SIZE];
  logic [LRQ_SIZE-1:0]  m_lrq   [LDQ_SIZE];
  int                   m_pipe  [LDQ_SIZE];
  int m_alloc, m_rel, m_count, loads_in, cycle_cnt;
  logic [CMT_ID_W-1:0]  next_cmt;
  logic [15:0]          lfsr;

  ldq_top i_dut (.*);

  bind ldq_top ldq_checker #(
    .LDQ_SIZE     (LDQ_SIZE),
    .LSU_INST_NUM (LSU_INST_NUM)
  ) u_checker (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_disp_valid      (i_disp_valid),
    .i_disp            (i_disp),
    .o_replay_index_oh (o_replay_index_oh),
    .o_done_report     (o_done_report)
  );

  initial i_clk = 1'b0;
  always #10 i_clk = ~i_clk;

  // ====================
  // Helpers
  // ====================
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic int replay_pick(input int p);
    for (int k = 0; k < LDQ_SIZE; k++) begin
      if (m_state[k] == READY && m_pipe[k] == p) return k;
    end
    return -1;
  endfunction

  task automatic fail_check(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic clear_inputs();
    i_disp_valid  = '0;
    i_disp_cmt_id = '0;
    for (int i = 0; i < DISP_SIZE; i++) i_disp[i] = '0;
    for (int p = 0; p < LSU_INST_NUM; p++) begin
      i_ex1_update[p] = '0;
      i_ex2_update[p] = '0;
    end
    i_tlb_resolve = '0;
    i_lrq_resolve = '0;
  endtask

  task automatic set_group(input int valid, input int is_load);
    int n;
    n = 0;
    for (int i = 0; i < DISP_SIZE; i++) begin
      i_disp[i].inst    = {16'hc0de, 8'(next_cmt), 8'(i)};
      i_disp[i].is_load = is_load[i];
      if (valid[i] && is_load[i]) n++;
    end
    i_disp_valid  = DISP_SIZE'(valid);
    i_disp_cmt_id = next_cmt;
    if (n > 0) next_cmt = next_cmt + 1'b1;  // Keeps live commit ids distinct
  endtask

  task automatic drive_ex1(input int p, input int k, input logic miss);
    i_ex1_update[p].update       = 1'b1;
    i_ex1_update[p].cmt_id       = m_cmt[k];
    i_ex1_update[p].grp_id       = m_grp[k];
    i_ex1_update[p].tlb_miss     = miss;
    i_ex1_update[p].pipe_sel_idx = PIPE_IDX_W'(p);
    i_ex1_update[p].vaddr        = VADDR_W'(k * 64);
    i_ex1_update[p].inst         = m_inst[k] ^ 32'h0000_0100;
  endtask

  task automatic drive_ex2(input int p, input int k, input hazard_t hz,
                           input logic [LRQ_SIZE-1:0] lrq);
    i_ex2_update[p].update       = 1'b1;
    i_ex2_update[p].index_oh     = LDQ_SIZE'(1) << k;
    i_ex2_update[p].hazard       = hz;
    i_ex2_update[p].lrq_index_oh = lrq;
  endtask

  // ====================
  // Checks and model
  // ====================
  task automatic check_outputs();
    int k;
    logic [LDQ_SIZE-1:0] exp_oh;
    for (int p = 0; p < LSU_INST_NUM; p++) begin
      k = replay_pick(p);
      if (k < 0) begin
        assert (!o_replay_valid[p] && !o_replay_issue[p].valid &&
                o_replay_index_oh[p] == '0)
          else fail_check($sformatf("unexpected replay on pipe %0d", p));
      end else begin
        exp_oh = '0;
        exp_oh[k] = 1'b1;
        assert (o_replay_valid[p] && o_replay_issue[p].valid &&
                o_replay_index_oh[p] == exp_oh && o_replay_issue[p].inst == m_inst[k])
          else fail_check($sformatf("replay of entry %0d on pipe %0d wrong", k, p));
      end
    end
    k = m_rel % LDQ_SIZE;
    if (m_count > 0 && m_state[k] == EX3_DONE) begin
      assert (o_done_report.valid && o_done_report.cmt_id == m_cmt[k] &&
              o_done_report.grp_id == m_grp[k])
        else fail_check($sformatf("done report of entry %0d wrong", k));
    end else begin
      assert (!o_done_report.valid) else fail_check("unexpected done report");
    end
  endtask

  task automatic advance_model();
    ldq_state_t          nxt [LDQ_SIZE];
    logic [LDQ_SIZE-1:0] granted;
    int                  k, seen, slot;
    granted = '0;
    for (int p = 0; p < LSU_INST_NUM; p++) begin
      k = replay_pick(p);
      if (k >= 0) granted[k] = 1'b1;
    end
    for (int e = 0; e < LDQ_SIZE; e++) begin
      nxt[e] = m_state[e];
      case (m_state[e])
        INIT: begin
          for (int p = 0; p < LSU_INST_NUM; p++) begin
            if (m_valid[e] && i_ex1_update[p].update && i_ex1_update[p].cmt_id == m_cmt[e] &&
                i_ex1_update[p].grp_id == m_grp[e]) begin
              nxt[e]    = i_ex1_update[p].tlb_miss ? TLB_HAZ : EX2_RUN;
              m_pipe[e] = int'(i_ex1_update[p].pipe_sel_idx);
              m_inst[e] = i_ex1_update[p].inst;
            end
          end
        end
        TLB_HAZ: if (|i_tlb_resolve) nxt[e] = EX2_RUN;
        EX2_RUN: begin
          for (int p = 0; p < LSU_INST_NUM; p++) begin
            if (i_ex2_update[p].update && i_ex2_update[p].index_oh[e]) begin
              m_lrq[e] = i_ex2_update[p].lrq_index_oh;
              case (i_ex2_update[p].hazard)
                NONE:         nxt[e] = EX3_DONE;
                L1D_CONFLICT: nxt[e] = READY;
                LRQ_CONFLICT: nxt[e] = (i_lrq_resolve.valid &&
                  i_lrq_resolve.resolve_index_oh == m_lrq[e]) ? READY : LRQ_HAZ;
                default:      nxt[e] = LRQ_HAZ;
              endcase
            end
          end
        end
        LRQ_HAZ: begin
          if (i_lrq_resolve.valid && i_lrq_resolve.resolve_index_oh == m_lrq[e]) nxt[e] = READY;
        end
        READY: if (granted[e]) nxt[e] = EX2_RUN;
        default: ;
      endcase
    end
    k = m_rel % LDQ_SIZE;
    if (m_count > 0 && m_state[k] == EX3_DONE) begin
      nxt[k]     = INIT;
      m_valid[k] = 1'b0;
      m_rel++;
      m_count--;
    end
    seen = 0;
    for (int i = 0; i < DISP_SIZE; i++) begin
      if (i_disp_valid[i] && i_disp[i].is_load && seen < MEM_DISP_SIZE) begin
        slot          = (m_alloc + seen) % LDQ_SIZE;
        m_valid[slot] = 1'b1;
        m_cmt[slot]   = i_disp_cmt_id;
        m_grp[slot]   = DISP_SIZE'(1) << i;
        m_inst[slot]  = i_disp[i].inst;
        seen++;
      end
    end
    m_alloc  += seen;
    m_count  += seen;
    loads_in += seen;
    for (int e = 0; e < LDQ_SIZE; e++) m_state[e] = nxt[e];
  endtask

  // One model cycle, ending at the next falling edge
  task automatic step();
    check_outputs();
    advance_model();
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d loads still queued", cycle_cnt, m_count);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
    @(negedge i_clk);
    clear_inputs();
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  // Drives every pending load to completion with no new hazards
  task automatic drain_all();
    int p1, p2;
    while (m_count > 0) begin
      p1 = 0;
      p2 = 0;
      for (int k = 0; k < LDQ_SIZE; k++) begin
        if (m_valid[k] && m_state[k] == INIT && p1 < LSU_INST_NUM) begin
          drive_ex1(p1, k, 1'b0);
          p1++;
        end else if (m_state[k] == EX2_RUN && p2 < LSU_INST_NUM) begin
          drive_ex2(p2, k, NONE, '0);
          p2++;
        end else if (m_state[k] == TLB_HAZ) begin
          i_tlb_resolve[0] = 1'b1;
        end else if (m_state[k] == LRQ_HAZ && !i_lrq_resolve.valid) begin
          i_lrq_resolve.valid            = 1'b1;
          i_lrq_resolve.resolve_index_oh = m_lrq[k];
        end
      end
      step();
    end
  endtask

  function automatic hazard_t pick_hazard();
    case (rand_bits(3))
      4:       return L1D_CONFLICT;
      5:       return LRQ_CONFLICT;
      6:       return LRQ_FULL;
      7:       return LRQ_ASSIGNED;
      default: return NONE;
    endcase
  endfunction

  task automatic random_cycle(input logic allow_disp);
    int p1, p2;
    p1 = 0;
    p2 = 0;
    if (allow_disp && m_count <= LDQ_SIZE - MEM_DISP_SIZE && rand_bits(1) == 1) begin
      set_group(rand_bits(DISP_SIZE), rand_bits(DISP_SIZE));
    end
    for (int k = 0; k < LDQ_SIZE; k++) begin
      if (m_valid[k] && m_state[k] == INIT && p1 < LSU_INST_NUM && rand_bits(1) == 1) begin
        drive_ex1(p1, k, rand_bits(2) == 0);
        p1++;
      end else if (m_state[k] == EX2_RUN && p2 < LSU_INST_NUM && rand_bits(1) == 1) begin
        drive_ex2(p2, k, pick_hazard(), LRQ_SIZE'(1) << rand_bits(2));
        p2++;
      end
    end
    if (rand_bits(2) == 0) i_tlb_resolve = LSU_INST_NUM'(rand_bits(LSU_INST_NUM));
    if (rand_bits(2) == 0) begin
      i_lrq_resolve.valid            = 1'b1;
      i_lrq_resolve.resolve_index_oh = LRQ_SIZE'(1) << rand_bits(2);
    end
    step();
  endtask

  // ====================
  // Test sequence
  // ====================
  initial begin
    int k0, k1;
    clear_inputs();
    i_reset_n = 1'b0;
    lfsr      = LFSR_SEED;
    next_cmt  = '0;
    m_alloc   = 0;
    m_rel     = 0;
    m_count   = 0;
    loads_in  = 0;
    cycle_cnt = 0;
    for (int k = 0; k < LDQ_SIZE; k++) begin
      m_state[k] = INIT;
      m_valid[k] = 1'b0;
      m_pipe[k]  = 0;
    end
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    idle(3);  // Quiet after reset

    // Mixed group with loads in slots 1 and 3
    k0 = m_alloc % LDQ_SIZE;
    k1 = (m_alloc + 1) % LDQ_SIZE;
    set_group(4'b1111, 4'b1010);
    step();
    drive_ex1(0, k0, 1'b0);
    drive_ex1(1, k1, 1'b0);
    step();
    drive_ex2(0, k0, NONE, '0);
    drive_ex2(1, k1, NONE, '0);
    step();
    drain_all();

    // TLB miss blocks the younger load
    k0 = m_alloc % LDQ_SIZE;
    k1 = (m_alloc + 1) % LDQ_SIZE;
    set_group(4'b0011, 4'b0011);
    step();
    drive_ex1(0, k0, 1'b1);
    drive_ex1(1, k1, 1'b0);
    step();
    drive_ex2(0, k1, NONE, '0);
    step();
    idle(3);
    i_tlb_resolve[0] = 1'b1;
    step();
    drive_ex2(0, k0, NONE, '0);
    step();
    drain_all();

    // Two L1D conflicts on pipe 0
    k0 = m_alloc % LDQ_SIZE;
    k1 = (m_alloc + 1) % LDQ_SIZE;
    set_group(4'b0011, 4'b0011);
    step();
    drive_ex1(0, k0, 1'b0);
    step();
    drive_ex1(0, k1, 1'b0);
    step();
    drive_ex2(0, k0, L1D_CONFLICT, '0);
    drive_ex2(1, k1, L1D_CONFLICT, '0);
    step();
    idle(2);
    drain_all();

    // LRQ full waits while a conflict resolves in the same cycle
    k0 = m_alloc % LDQ_SIZE;
    k1 = (m_alloc + 1) % LDQ_SIZE;
    set_group(4'b0101, 4'b0101);
    step();
    drive_ex1(0, k0, 1'b0);
    drive_ex1(1, k1, 1'b0);
    step();
    drive_ex2(0, k0, LRQ_FULL, 4'b0001);
    drive_ex2(1, k1, LRQ_CONFLICT, 4'b0010);
    i_lrq_resolve = '{valid: 1'b1, resolve_index_oh: 4'b0010};
    step();
    idle(2);
    i_lrq_resolve = '{valid: 1'b1, resolve_index_oh: 4'b0100};
    step();
    idle(1);
    i_lrq_resolve = '{valid: 1'b1, resolve_index_oh: 4'b0001};
    step();
    idle(2);
    drain_all();

    // Random traffic
    while (loads_in < DIRECTED_LOADS + RAND_LOADS) random_cycle(1'b1);
    drain_all();
    idle(2);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: verification/ldq_checker.sv
`timescale 1ns/1ps

module ldq_checker #(
  parameter int LDQ_SIZE     = ldq_pkg::LDQ_SIZE,
  parameter int LSU_INST_NUM = lsu_core_pkg::LSU_INST_NUM
) (
  input logic                               i_clk,
  input logic                               i_reset_n,
  input logic [lsu_core_pkg::DISP_SIZE-1:0] i_disp_valid,
  input lsu_core_pkg::disp_t                i_disp [lsu_core_pkg::DISP_SIZE],
  input logic [LDQ_SIZE-1:0]                o_replay_index_oh [LSU_INST_NUM],
  input lsu_core_pkg::done_rpt_t            o_done_report
);
  import lsu_core_pkg::*;

  localparam int CNT_W = $clog2(LDQ_SIZE) + 2;

  logic [CNT_W-1:0] r_occupancy;
  logic [CNT_W-1:0] w_picks;

  // Loads taken from the group, at most MEM_DISP_SIZE
  always_comb begin
    w_picks = '0;
    for (int i = 0; i < DISP_SIZE; i++) begin
      if (i_disp_valid[i] && i_disp[i].is_load && w_picks < CNT_W'(MEM_DISP_SIZE)) begin
        w_picks = w_picks + CNT_W'(1);
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_occupancy <= '0;
    end else begin
      r_occupancy <= r_occupancy + w_picks - CNT_W'(o_done_report.valid);
    end
  end

  // ====================
  for (genvar p = 0; p < LSU_INST_NUM; p++) begin : g_pipe
    a_replay_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      $onehot0(o_replay_index_oh[p]))
      else $error("Replay index on pipe %0d is not one-hot", p);
  end

  a_no_done_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done_report.valid |-> r_occupancy != '0)
    else $error("Done reported while the queue is empty");

  a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_occupancy + w_picks <= CNT_W'(LDQ_SIZE))
    else $error("Dispatch exceeds the free queue entries");

endmodule

// File: rtl/ldq_top.sv
`timescale 1ns/1ps

module ldq_top #(
  parameter int LDQ_SIZE     = ldq_pkg::LDQ_SIZE,
  parameter int LSU_INST_NUM = lsu_core_pkg::LSU_INST_NUM
) (
  input  logic                               i_clk,
  input  logic                               i_reset_n,

  // Dispatch group
  input  logic [lsu_core_pkg::DISP_SIZE-1:0] i_disp_valid,
  input  lsu_core_pkg::disp_t                i_disp [lsu_core_pkg::DISP_SIZE],
  input  logic [lsu_core_pkg::CMT_ID_W-1:0]  i_disp_cmt_id,

  // LSU pipeline updates
  input  ldq_pkg::ex1_update_t               i_ex1_update [LSU_INST_NUM],
  input  ldq_pkg::ex2_update_t               i_ex2_update [LSU_INST_NUM],
  input  logic [LSU_INST_NUM-1:0]            i_tlb_resolve,
  input  ldq_pkg::lrq_resolve_t              i_lrq_resolve,

  // Replay towards the pipes
  output logic [LSU_INST_NUM-1:0]            o_replay_valid,
  output lsu_core_pkg::issue_t               o_replay_issue    [LSU_INST_NUM],
  output logic [LDQ_SIZE-1:0]                o_replay_index_oh [LSU_INST_NUM],

  output lsu_core_pkg::done_rpt_t            o_done_report
);

  logic [$clog2(LDQ_SIZE)-1:0] w_alloc_ptr;

  ldq_alloc_if u_alloc_if ();
  ldq_entry_if u_entry_if [LDQ_SIZE] ();

  ldq_disp_pickup u_pickup (
    .i_disp_valid  (i_disp_valid),
    .i_disp        (i_disp),
    .i_disp_cmt_id (i_disp_cmt_id),
    .alloc         (u_alloc_if)
  );

  for (genvar k = 0; k < LDQ_SIZE; k++) begin : g_entry
    ldq_entry #(
      .LDQ_SIZE     (LDQ_SIZE),
      .LSU_INST_NUM (LSU_INST_NUM),
      .ENTRY_IDX    (k)
    ) u_entry (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .alloc         (u_alloc_if),
      .i_alloc_ptr   (w_alloc_ptr),
      .i_ex1_update  (i_ex1_update),
      .i_ex2_update  (i_ex2_update),
      .i_tlb_resolve (i_tlb_resolve),
      .i_lrq_resolve (i_lrq_resolve),
      .ports         (u_entry_if[k])
    );
  end

  ldq_replay_arb #(
    .LDQ_SIZE     (LDQ_SIZE),
    .LSU_INST_NUM (LSU_INST_NUM)
  ) u_replay_arb (
    .entries           (u_entry_if),
    .o_replay_valid    (o_replay_valid),
    .o_replay_issue    (o_replay_issue),
    .o_replay_index_oh (o_replay_index_oh)
  );

  ldq_order_ctrl #(
    .LDQ_SIZE (LDQ_SIZE)
  ) u_order_ctrl (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .alloc         (u_alloc_if),
    .entries       (u_entry_if),
    .o_alloc_ptr   (w_alloc_ptr),
    .o_done_report (o_done_report)
  );

endmodule

// File: rtl/ldq_order_ctrl.sv
`timescale 1ns/1ps

module ldq_order_ctrl #(
  parameter int LDQ_SIZE = ldq_pkg::LDQ_SIZE
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  ldq_alloc_if.queue                  alloc,
  ldq_entry_if.select                 entries [LDQ_SIZE],
  output logic [$clog2(LDQ_SIZE)-1:0] o_alloc_ptr,
  output lsu_core_pkg::done_rpt_t     o_done_report
);
  import lsu_core_pkg::*;

  localparam int PTR_W = $clog2(LDQ_SIZE);
  localparam int CNT_W = PTR_W + 1;  // Extra wrap bit

  logic [CNT_W-1:0]     r_alloc_ptr;
  logic [CNT_W-1:0]     r_rel_ptr;
  logic [PTR_W-1:0]     w_rel_idx;
  logic                 w_empty;
  logic                 w_done_valid;
  logic [LDQ_SIZE-1:0]  w_done_ready;
  logic [CMT_ID_W-1:0]  w_cmt_id [LDQ_SIZE];
  logic [DISP_SIZE-1:0] w_grp_id [LDQ_SIZE];

  assign w_rel_idx    = r_rel_ptr[PTR_W-1:0];
  assign w_empty      = r_alloc_ptr == r_rel_ptr;
  assign w_done_valid = !w_empty && w_done_ready[w_rel_idx];

  // ====================
  // Done selection
  // ====================
  for (genvar k = 0; k < LDQ_SIZE; k++) begin : g_entry
    assign w_done_ready[k] = entries[k].done_ready;
    assign w_cmt_id[k]     = entries[k].cmt_id;
    assign w_grp_id[k]     = entries[k].grp_id;
    assign entries[k].done_grant = w_done_valid && w_rel_idx == PTR_W'(k);
  end

  assign o_done_report.valid  = w_done_valid;
  assign o_done_report.cmt_id = w_cmt_id[w_rel_idx];
  assign o_done_report.grp_id = w_grp_id[w_rel_idx];

  // ====================
  // Pointers
  // ====================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_alloc_ptr <= '0;
      r_rel_ptr   <= '0;
    end else begin
      r_alloc_ptr <= r_alloc_ptr + CNT_W'(alloc.pick_cnt);
      if (w_done_valid) begin
        r_rel_ptr <= r_rel_ptr + CNT_W'(1);  // One load retires per cycle
      end
    end
  end

  assign o_alloc_ptr = r_alloc_ptr[PTR_W-1:0];

endmodule

// File: rtl/ldq_replay_arb.sv
`timescale 1ns/1ps

module ldq_replay_arb #(
  parameter int LDQ_SIZE     = ldq_pkg::LDQ_SIZE,
  parameter int LSU_INST_NUM = lsu_core_pkg::LSU_INST_NUM
) (
  ldq_entry_if.select          entries [LDQ_SIZE],
  output logic [LSU_INST_NUM-1:0] o_replay_valid,
  output lsu_core_pkg::issue_t    o_replay_issue    [LSU_INST_NUM],
  output logic [LDQ_SIZE-1:0]     o_replay_index_oh [LSU_INST_NUM]
);
  import lsu_core_pkg::*;
  import ldq_pkg::*;

  logic [LDQ_SIZE-1:0]   w_ready;
  logic [PIPE_IDX_W-1:0] w_pipe     [LDQ_SIZE];
  logic [INST_W-1:0]     w_inst     [LDQ_SIZE];
  logic [LDQ_SIZE-1:0]   w_req      [LSU_INST_NUM];
  logic [LDQ_SIZE-1:0]   w_grant_oh [LSU_INST_NUM];
  logic [LDQ_SIZE-1:0]   w_grant_any;

  for (genvar k = 0; k < LDQ_SIZE; k++) begin : g_entry
    assign w_ready[k] = entries[k].replay_req;
    assign w_pipe[k]  = entries[k].pipe_sel_idx;
    assign w_inst[k]  = entries[k].inst;
    assign entries[k].replay_grant = w_grant_any[k];
  end

  for (genvar p = 0; p < LSU_INST_NUM; p++) begin : g_pipe
    logic [INST_W-1:0] w_sel_inst;

    always_comb begin
      for (int k = 0; k < LDQ_SIZE; k++) begin
        w_req[p][k] = w_ready[k] && w_pipe[k] == PIPE_IDX_W'(p);
      end
    end

    // Lowest ready index wins
    assign w_grant_oh[p] = w_req[p] & (~w_req[p] + 1'b1);

    always_comb begin
      w_sel_inst = '0;
      for (int k = 0; k < LDQ_SIZE; k++) begin
        w_sel_inst = w_sel_inst | (w_inst[k] & {INST_W{w_grant_oh[p][k]}});
      end
    end

    assign o_replay_valid[p]       = |w_req[p];
    assign o_replay_issue[p].valid = |w_req[p];
    assign o_replay_issue[p].inst  = w_sel_inst;
    assign o_replay_index_oh[p]    = w_grant_oh[p];
  end

  always_comb begin
    w_grant_any = '0;
    for (int p = 0; p < LSU_INST_NUM; p++) begin
      w_grant_any = w_grant_any | w_grant_oh[p];
    end
  end

endmodule

// File: rtl/ldq_entry.sv
`timescale 1ns/1ps

module ldq_entry #(
  parameter int LDQ_SIZE     = ldq_pkg::LDQ_SIZE,
  parameter int LSU_INST_NUM = lsu_core_pkg::LSU_INST_NUM,
  parameter int ENTRY_IDX    = 0
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  ldq_alloc_if.queue                    alloc,
  input  logic [$clog2(LDQ_SIZE)-1:0]   i_alloc_ptr,
  input  ldq_pkg::ex1_update_t          i_ex1_update [LSU_INST_NUM],
  input  ldq_pkg::ex2_update_t          i_ex2_update [LSU_INST_NUM],
  input  logic [LSU_INST_NUM-1:0]       i_tlb_resolve,
  input  ldq_pkg::lrq_resolve_t         i_lrq_resolve,
  ldq_entry_if.entry                    ports
);
  import lsu_core_pkg::*;
  import ldq_pkg::*;

  localparam int PTR_W = $clog2(LDQ_SIZE);

  logic                  r_valid;
  ldq_state_t            r_state;
  logic [CMT_ID_W-1:0]   r_cmt_id;
  logic [DISP_SIZE-1:0]  r_grp_id;
  logic [PIPE_IDX_W-1:0] r_pipe_sel_idx;
  logic [INST_W-1:0]     r_inst;
  logic [LRQ_SIZE-1:0]   r_lrq_index_oh;

  logic                 w_alloc_hit;
  logic [INST_W-1:0]    w_alloc_inst;
  logic [DISP_SIZE-1:0] w_alloc_grp_id;
  logic                 w_ex1_hit;
  ex1_update_t          w_ex1_sel;
  logic                 w_ex2_hit;
  ex2_update_t          w_ex2_sel;
  logic                 w_lrq_same_cycle;
  logic                 w_lrq_wakeup;

  // ====================
  // Update matching
  // ====================
  always_comb begin : alloc_match
    logic [PTR_W-1:0] slot_ptr;
    w_alloc_hit    = 1'b0;
    w_alloc_inst   = '0;
    w_alloc_grp_id = '0;
    for (int j = 0; j < MEM_DISP_SIZE; j++) begin
      slot_ptr = i_alloc_ptr + PTR_W'(j);
      if (alloc.slot_valid[j] && slot_ptr == PTR_W'(ENTRY_IDX)) begin
        w_alloc_hit    = 1'b1;
        w_alloc_inst   = alloc.slot_inst[j];
        w_alloc_grp_id = alloc.slot_grp_id[j];
      end
    end
  end

  always_comb begin
    w_ex1_hit = 1'b0;
    w_ex1_sel = '0;
    for (int p = 0; p < LSU_INST_NUM; p++) begin
      if (!w_ex1_hit && i_ex1_update[p].update &&
          i_ex1_update[p].cmt_id == r_cmt_id && i_ex1_update[p].grp_id == r_grp_id) begin
        w_ex1_hit = r_valid;
        w_ex1_sel = i_ex1_update[p];
      end
    end
  end

  always_comb begin
    w_ex2_hit = 1'b0;
    w_ex2_sel = '0;
    for (int p = 0; p < LSU_INST_NUM; p++) begin
      if (!w_ex2_hit && i_ex2_update[p].update && i_ex2_update[p].index_oh[ENTRY_IDX]) begin
        w_ex2_hit = 1'b1;
        w_ex2_sel = i_ex2_update[p];
      end
    end
  end

  // Conflict already resolved while EX2 reports it
  assign w_lrq_same_cycle = i_lrq_resolve.valid &&
                            i_lrq_resolve.resolve_index_oh == w_ex2_sel.lrq_index_oh;
  assign w_lrq_wakeup     = i_lrq_resolve.valid &&
                            i_lrq_resolve.resolve_index_oh == r_lrq_index_oh;

  // ====================
  // Entry FSM
  // ====================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
      r_state <= INIT;
    end else begin
      case (r_state)
        INIT: begin
          if (w_alloc_hit) begin
            r_valid <= 1'b1;
          end else if (w_ex1_hit) begin
            r_state <= w_ex1_sel.tlb_miss ? TLB_HAZ : EX2_RUN;
          end
        end
        TLB_HAZ: if (|i_tlb_resolve) r_state <= EX2_RUN;
        EX2_RUN: begin
          if (w_ex2_hit) begin
            case (w_ex2_sel.hazard)
              NONE:         r_state <= EX3_DONE;
              L1D_CONFLICT: r_state <= READY;
              LRQ_CONFLICT: r_state <= w_lrq_same_cycle ? READY : LRQ_HAZ;
              default:      r_state <= LRQ_HAZ;  // LRQ full or assigned
            endcase
          end
        end
        LRQ_HAZ: if (w_lrq_wakeup) r_state <= READY;
        READY:   if (ports.replay_grant) r_state <= EX2_RUN;
        EX3_DONE: begin
          if (ports.done_grant) begin
            r_state <= INIT;
            r_valid <= 1'b0;
          end
        end
        default: r_state <= INIT;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (r_state == INIT && w_alloc_hit) begin
      r_cmt_id <= alloc.cmt_id;
      r_grp_id <= w_alloc_grp_id;
      r_inst   <= w_alloc_inst;
    end else if (r_state == INIT && w_ex1_hit) begin
      r_pipe_sel_idx <= w_ex1_sel.pipe_sel_idx;
      r_inst         <= w_ex1_sel.inst;
    end
    if (r_state == EX2_RUN && w_ex2_hit) begin
      r_lrq_index_oh <= w_ex2_sel.lrq_index_oh;
    end
  end

  assign ports.replay_req   = r_state == READY;
  assign ports.done_ready   = r_state == EX3_DONE;
  assign ports.pipe_sel_idx = r_pipe_sel_idx;
  assign ports.inst         = r_inst;
  assign ports.cmt_id       = r_cmt_id;
  assign ports.grp_id       = r_grp_id;

endmodule

// File: rtl/ldq_disp_pickup.sv
`timescale 1ns/1ps

module ldq_disp_pickup (
  input  logic [lsu_core_pkg::DISP_SIZE-1:0] i_disp_valid,
  input  lsu_core_pkg::disp_t                i_disp [lsu_core_pkg::DISP_SIZE],
  input  logic [lsu_core_pkg::CMT_ID_W-1:0]  i_disp_cmt_id,
  ldq_alloc_if.pickup                        alloc
);
  import lsu_core_pkg::*;

  localparam int SEEN_W = $clog2(DISP_SIZE + 1);

  logic [DISP_SIZE-1:0] w_is_load;

  always_comb begin
    for (int i = 0; i < DISP_SIZE; i++) begin
      w_is_load[i] = i_disp_valid[i] & i_disp[i].is_load;
    end
  end

  // Load number n of the group lands in slot n
  always_comb begin : compact
    logic [SEEN_W-1:0] seen;
    seen = '0;
    alloc.slot_valid = '0;
    for (int j = 0; j < MEM_DISP_SIZE; j++) begin
      alloc.slot_inst[j]   = '0;
      alloc.slot_grp_id[j] = '0;
    end
    for (int i = 0; i < DISP_SIZE; i++) begin
      if (w_is_load[i]) begin
        for (int j = 0; j < MEM_DISP_SIZE; j++) begin
          if (seen == SEEN_W'(j)) begin
            alloc.slot_valid[j]     = 1'b1;
            alloc.slot_inst[j]      = i_disp[i].inst;
            alloc.slot_grp_id[j][i] = 1'b1;
          end
        end
        seen = seen + SEEN_W'(1);
      end
    end
  end

  always_comb begin
    alloc.pick_cnt = '0;
    for (int j = 0; j < MEM_DISP_SIZE; j++) begin
      alloc.pick_cnt = alloc.pick_cnt + PICK_CNT_W'(alloc.slot_valid[j]);
    end
  end

  assign alloc.cmt_id = i_disp_cmt_id;

endmodule

// File: rtl/ldq_entry_if.sv
`timescale 1ns/1ps

interface ldq_entry_if;
  import lsu_core_pkg::*;
  import ldq_pkg::*;

  logic                  replay_req;
  logic [PIPE_IDX_W-1:0] pipe_sel_idx;
  logic [INST_W-1:0]     inst;
  logic                  done_ready;
  logic [CMT_ID_W-1:0]   cmt_id;
  logic [DISP_SIZE-1:0]  grp_id;
  logic                  replay_grant;
  logic                  done_grant;

  modport entry (
    output replay_req, pipe_sel_idx, inst, done_ready, cmt_id, grp_id,
    input  replay_grant, done_grant
  );

  modport select (
    input  replay_req, pipe_sel_idx, inst, done_ready, cmt_id, grp_id,
    output replay_grant, done_grant
  );

endinterface

// File: rtl/ldq_alloc_if.sv
`timescale 1ns/1ps

interface ldq_alloc_if;
  import lsu_core_pkg::*;

  logic [MEM_DISP_SIZE-1:0] slot_valid;
  logic [INST_W-1:0]        slot_inst   [MEM_DISP_SIZE];
  logic [DISP_SIZE-1:0]     slot_grp_id [MEM_DISP_SIZE];  // One-hot group position
  logic [CMT_ID_W-1:0]      cmt_id;
  logic [PICK_CNT_W-1:0]    pick_cnt;

  modport pickup (
    output slot_valid, slot_inst, slot_grp_id, cmt_id, pick_cnt
  );

  modport queue (
    input slot_valid, slot_inst, slot_grp_id, cmt_id, pick_cnt
  );

endinterface

// File: rtl/ldq_pkg.sv
package ldq_pkg;

  localparam int LDQ_SIZE = 8;
  localparam int LRQ_SIZE = 4;
  localparam int VADDR_W  = 39;

  // Pipe index, kept one bit wide for a single pipe
  localparam int PIPE_IDX_W = (lsu_core_pkg::LSU_INST_NUM > 1) ?
                              $clog2(lsu_core_pkg::LSU_INST_NUM) : 1;

  // EX2 result
  typedef enum logic [2:0] {
    NONE         = 3'd0,
    L1D_CONFLICT = 3'd1,
    LRQ_CONFLICT = 3'd2,
    LRQ_FULL     = 3'd3,
    LRQ_ASSIGNED = 3'd4
  } hazard_t;

  typedef enum logic [2:0] {
    INIT     = 3'd0,
    TLB_HAZ  = 3'd1,
    EX2_RUN  = 3'd2,
    LRQ_HAZ  = 3'd3,
    READY    = 3'd4,
    EX3_DONE = 3'd5
  } ldq_state_t;

  typedef struct packed {
    logic                                update;
    logic [lsu_core_pkg::CMT_ID_W-1:0]   cmt_id;
    logic [lsu_core_pkg::DISP_SIZE-1:0]  grp_id;
    logic                                tlb_miss;
    logic [PIPE_IDX_W-1:0]               pipe_sel_idx;
    logic [VADDR_W-1:0]                  vaddr;
    logic [lsu_core_pkg::INST_W-1:0]     inst;
  } ex1_update_t;

  typedef struct packed {
    logic                update;
    logic [LDQ_SIZE-1:0] index_oh;
    hazard_t             hazard;
    logic [LRQ_SIZE-1:0] lrq_index_oh;
  } ex2_update_t;

  typedef struct packed {
    logic                valid;
    logic [LRQ_SIZE-1:0] resolve_index_oh;
  } lrq_resolve_t;

endpackage

// File: rtl/lsu_core_pkg.sv
package lsu_core_pkg;

  // ====================
  // Core sizes
  // ====================
  localparam int DISP_SIZE     = 4;
  localparam int MEM_DISP_SIZE = 2;
  localparam int LSU_INST_NUM  = 2;
  localparam int CMT_ID_W      = 4;
  localparam int INST_W        = 32;

  // Count of compacted memory ops, 0 to MEM_DISP_SIZE
  localparam int PICK_CNT_W = $clog2(MEM_DISP_SIZE + 1);

  // ====================
  // Dispatch and issue
  // ====================
  typedef struct packed {
    logic [INST_W-1:0] inst;
    logic              is_load;
  } disp_t;

  typedef struct packed {
    logic              valid;
    logic [INST_W-1:0] inst;
  } issue_t;

  // In-order completion towards the commit logic
  typedef struct packed {
    logic                 valid;
    logic [CMT_ID_W-1:0]  cmt_id;
    logic [DISP_SIZE-1:0] grp_id;  // One-hot slot in the group
  } done_rpt_t;

endpackage
